//--- logic/bomb_pkg.sv
package bomb_pkg;

  // playfield grid
  localparam int MAP_NUM_ROW = 11;
  localparam int MAP_NUM_COL = 19;
  localparam int MAP_DEPTH   = MAP_NUM_ROW * MAP_NUM_COL;
  localparam int ADDR_WIDTH  = $clog2(MAP_DEPTH);
  localparam int ROW_WIDTH   = $clog2(MAP_NUM_ROW);
  localparam int COL_WIDTH   = $clog2(MAP_NUM_COL);

  // bomb slots
  localparam int NUM_BOMBS    = 3;
  localparam int SLOT_WIDTH   = $clog2(NUM_BOMBS);
  localparam int ACTIVE_WIDTH = $clog2(NUM_BOMBS + 1);

  // frame ticks, place write to blast
  localparam int FUSE_TICKS  = 4;
  // frame ticks the blast stays on screen
  localparam int BLAST_TICKS = 2;
  // shared by fuse and blast counting, so it must hold both
  localparam int FUSE_WIDTH  = $clog2(FUSE_TICKS + 1);

  // centre plus four arms
  localparam int CROSS_CELLS = 5;
  localparam int CROSS_WIDTH = $clog2(CROSS_CELLS);

  // map cell contents
  typedef enum logic [1:0] {
    TILE_FREE  = 2'd0,
    TILE_WALL  = 2'd1,
    TILE_BRICK = 2'd2,
    TILE_BOMB  = 2'd3
  } tile_t;

  // map write opcodes
  typedef enum logic {
    OP_PLACE = 1'b0,
    OP_CLEAR = 1'b1
  } wr_op_t;

  // per-bomb life cycle
  typedef enum logic [2:0] {
    SLOT_IDLE  = 3'd0,
    SLOT_PLACE = 3'd1,
    SLOT_FUSE  = 3'd2,
    SLOT_BURST = 3'd3,
    SLOT_BLAST = 3'd4
  } slot_state_t;

endpackage

//--- logic/bomb_dispatch.sv
module bomb_dispatch (
  input  logic                           pixclk,
  input  logic                           i_rst_n,
  input  logic                           i_place_bomb,
  input  logic [bomb_pkg::ROW_WIDTH-1:0] i_player_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0] i_player_col,
  input  logic [bomb_pkg::NUM_BOMBS-1:0] i_slot_busy,
  input  logic [bomb_pkg::ROW_WIDTH-1:0] i_slot_row [bomb_pkg::NUM_BOMBS],
  input  logic [bomb_pkg::COL_WIDTH-1:0] i_slot_col [bomb_pkg::NUM_BOMBS],
  output logic [bomb_pkg::NUM_BOMBS-1:0] o_arm,
  output logic [bomb_pkg::ROW_WIDTH-1:0] o_arm_row,
  output logic [bomb_pkg::COL_WIDTH-1:0] o_arm_col
);
  import bomb_pkg::*;

  // slots taken, including one armed this cycle but not yet busy
  logic [NUM_BOMBS-1:0] busy_eff;
  // one-hot pick of the lowest free slot
  logic [NUM_BOMBS-1:0] arm_next;
  logic                 free_found;
  logic                 dup_hit;
  logic                 accept;

  always_comb begin
    busy_eff = i_slot_busy | o_arm;

    // same cell already holds a live bomb
    dup_hit = 1'b0;
    for (int i = 0; i < NUM_BOMBS; i++) begin
      if (i_slot_busy[i] && i_slot_row[i] == i_player_row &&
          i_slot_col[i] == i_player_col) begin
        dup_hit = 1'b1;
      end
    end
    // pending arm counts too, its slot has not latched the cell yet
    if (|o_arm && o_arm_row == i_player_row && o_arm_col == i_player_col) begin
      dup_hit = 1'b1;
    end

    // lowest index wins
    arm_next   = '0;
    free_found = 1'b0;
    for (int i = 0; i < NUM_BOMBS; i++) begin
      if (!free_found && !busy_eff[i]) begin
        arm_next[i] = 1'b1;
        free_found  = 1'b1;
      end
    end
  end

  assign accept = i_place_bomb && free_found && !dup_hit;

  // one-cycle arm strobe
  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      o_arm <= '0;
    end else if (accept) begin
      o_arm <= arm_next;
    end else begin
      o_arm <= '0;
    end
  end

  // cell travels with the strobe
  always_ff @(posedge pixclk) begin
    if (accept) begin
      o_arm_row <= i_player_row;
      o_arm_col <= i_player_col;
    end
  end

endmodule

//--- logic/bomb_slot.sv
module bomb_slot (
  input  logic                            pixclk,
  input  logic                            i_rst_n,
  input  logic                            i_tick,
  input  logic                            i_arm,
  input  logic [bomb_pkg::ROW_WIDTH-1:0]  i_arm_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0]  i_arm_col,
  input  logic                            i_grant,
  output logic                            o_busy,
  output logic [bomb_pkg::ROW_WIDTH-1:0]  o_row,
  output logic [bomb_pkg::COL_WIDTH-1:0]  o_col,
  output logic                            o_req,
  output bomb_pkg::wr_op_t                o_op,
  output logic [bomb_pkg::ROW_WIDTH-1:0]  o_req_row,
  output logic [bomb_pkg::COL_WIDTH-1:0]  o_req_col,
  output logic [bomb_pkg::FUSE_WIDTH-1:0] o_fuse_left,
  output logic                            o_blasting
);
  import bomb_pkg::*;

  slot_state_t            state;
  // fuse ticks in FUSE, hold ticks in BLAST
  logic [FUSE_WIDTH-1:0]  cnt;
  // 0 centre, 1 up, 2 down, 3 left, 4 right
  logic [CROSS_WIDTH-1:0] cross_idx;
  logic [ROW_WIDTH-1:0]   tgt_row;
  logic [COL_WIDTH-1:0]   tgt_col;
  logic                   cell_ok;
  logic                   last_cell;

  // cross cell for the current burst step
  always_comb begin
    tgt_row = o_row;
    tgt_col = o_col;
    cell_ok = 1'b1;
    case (cross_idx)
      CROSS_WIDTH'(0): cell_ok = 1'b1;
      CROSS_WIDTH'(1): begin
        tgt_row = o_row - 1'b1;
        cell_ok = (o_row != '0);
      end
      CROSS_WIDTH'(2): begin
        tgt_row = o_row + 1'b1;
        cell_ok = (o_row < ROW_WIDTH'(MAP_NUM_ROW - 1));
      end
      CROSS_WIDTH'(3): begin
        tgt_col = o_col - 1'b1;
        cell_ok = (o_col != '0);
      end
      CROSS_WIDTH'(4): begin
        tgt_col = o_col + 1'b1;
        cell_ok = (o_col < COL_WIDTH'(MAP_NUM_COL - 1));
      end
      default: cell_ok = 1'b0;
    endcase
  end

  assign last_cell = (cross_idx == CROSS_WIDTH'(CROSS_CELLS - 1));

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      state     <= SLOT_IDLE;
      cnt       <= '0;
      cross_idx <= '0;
    end else begin
      case (state)
        SLOT_IDLE: if (i_arm) begin
          state <= SLOT_PLACE;
          cnt   <= FUSE_WIDTH'(FUSE_TICKS);
        end
        // fuse waits for the place write to land
        SLOT_PLACE: if (i_grant) state <= SLOT_FUSE;
        SLOT_FUSE: if (i_tick) begin
          cnt <= cnt - 1'b1;
          if (cnt == FUSE_WIDTH'(1)) begin
            state     <= SLOT_BURST;
            cross_idx <= '0;
          end
        end
        // off-grid cells are stepped over without a request
        SLOT_BURST: if (i_grant || !cell_ok) begin
          if (last_cell) begin
            state <= SLOT_BLAST;
            cnt   <= FUSE_WIDTH'(BLAST_TICKS);
          end else begin
            cross_idx <= cross_idx + 1'b1;
          end
        end
        SLOT_BLAST: if (i_tick) begin
          cnt <= cnt - 1'b1;
          if (cnt == FUSE_WIDTH'(1)) state <= SLOT_IDLE;
        end
        default: state <= SLOT_IDLE;
      endcase
    end
  end

  // bomb cell, held for the whole life
  always_ff @(posedge pixclk) begin
    if (state == SLOT_IDLE && i_arm) begin
      o_row <= i_arm_row;
      o_col <= i_arm_col;
    end
  end

  assign o_busy      = (state != SLOT_IDLE);
  assign o_req       = (state == SLOT_PLACE) || (state == SLOT_BURST && cell_ok);
  assign o_op        = (state == SLOT_BURST) ? OP_CLEAR : OP_PLACE;
  assign o_req_row   = (state == SLOT_BURST) ? tgt_row : o_row;
  assign o_req_col   = (state == SLOT_BURST) ? tgt_col : o_col;
  // zero outside the fuse phases
  assign o_fuse_left = (state == SLOT_PLACE || state == SLOT_FUSE) ? cnt : '0;
  assign o_blasting  = (state == SLOT_BLAST);

endmodule

//--- logic/bomb_collector.sv
module bomb_collector (
  input  logic                              pixclk,
  input  logic                              i_rst_n,
  input  logic [bomb_pkg::NUM_BOMBS-1:0]    i_req,
  input  bomb_pkg::wr_op_t                  i_op [bomb_pkg::NUM_BOMBS],
  input  logic [bomb_pkg::ROW_WIDTH-1:0]    i_req_row [bomb_pkg::NUM_BOMBS],
  input  logic [bomb_pkg::COL_WIDTH-1:0]    i_req_col [bomb_pkg::NUM_BOMBS],
  input  logic [bomb_pkg::FUSE_WIDTH-1:0]   i_fuse_left [bomb_pkg::NUM_BOMBS],
  input  logic [bomb_pkg::NUM_BOMBS-1:0]    i_fuse_valid,
  input  logic [bomb_pkg::NUM_BOMBS-1:0]    i_blasting,
  input  logic [bomb_pkg::ROW_WIDTH-1:0]    i_player_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0]    i_player_col,
  output logic [bomb_pkg::NUM_BOMBS-1:0]    o_grant,
  output logic                              o_we,
  output bomb_pkg::wr_op_t                  o_wr_op,
  output logic [bomb_pkg::ROW_WIDTH-1:0]    o_wr_row,
  output logic [bomb_pkg::COL_WIDTH-1:0]    o_wr_col,
  output logic [bomb_pkg::FUSE_WIDTH-1:0]   o_countdown,
  output logic [bomb_pkg::ACTIVE_WIDTH-1:0] o_bombs_active,
  output logic                              o_blast,
  output logic                              o_game_over
);
  import bomb_pkg::*;

  // first slot looked at this cycle
  logic [SLOT_WIDTH-1:0] ptr;
  int                    win_idx;
  logic                  found;
  logic                  hit_player;

  // round-robin search starting at ptr
  always_comb begin
    int cand;
    o_grant = '0;
    win_idx = int'(ptr);
    found   = 1'b0;
    for (int k = 0; k < NUM_BOMBS; k++) begin
      cand = (int'(ptr) + k) % NUM_BOMBS;
      if (!found && i_req[cand]) begin
        o_grant[cand] = 1'b1;
        win_idx       = cand;
        found         = 1'b1;
      end
    end
  end

  // winner's write goes straight to the map
  assign o_we     = found;
  assign o_wr_op  = i_op[win_idx];
  assign o_wr_row = i_req_row[win_idx];
  assign o_wr_col = i_req_col[win_idx];

  // pointer moves past the winner
  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= SLOT_WIDTH'((win_idx + 1) % NUM_BOMBS);
    end
  end

  assign hit_player = o_we && o_wr_op == OP_CLEAR &&
                      o_wr_row == i_player_row && o_wr_col == i_player_col;

  // sticky until reset
  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      o_game_over <= 1'b0;
    end else if (hit_player) begin
      o_game_over <= 1'b1;
    end
  end

  // display summaries
  always_comb begin
    o_countdown    = '0;
    o_bombs_active = '0;
    o_blast        = 1'b0;
    for (int i = 0; i < NUM_BOMBS; i++) begin
      if (i_fuse_valid[i]) o_bombs_active = o_bombs_active + 1'b1;
      // nonzero fuse_left only while placing or fusing
      if (i_fuse_valid[i] && i_fuse_left[i] != '0 &&
          (o_countdown == '0 || i_fuse_left[i] < o_countdown)) begin
        o_countdown = i_fuse_left[i];
      end
      o_blast = o_blast | i_blasting[i];
    end
  end

endmodule

//--- logic/tile_map.sv
module tile_map (
  input  logic                           pixclk,
  input  logic                           i_rst_n,
  input  logic                           i_we,
  input  bomb_pkg::wr_op_t               i_wr_op,
  input  logic [bomb_pkg::ROW_WIDTH-1:0] i_wr_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0] i_wr_col,
  input  logic [bomb_pkg::ROW_WIDTH-1:0] i_rd_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0] i_rd_col,
  output bomb_pkg::tile_t                o_rd_tile
);
  import bomb_pkg::*;

  tile_t                 mem [MAP_DEPTH];
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  wr_in_grid;
  logic                  rd_in_grid;

  // start layout, walls on border and even/even, bricks on thirds
  function automatic tile_t init_tile(input int r, input int c);
    if (r == 0 || r == MAP_NUM_ROW - 1 || c == 0 || c == MAP_NUM_COL - 1) return TILE_WALL;
    if (r % 2 == 0 && c % 2 == 0) return TILE_WALL;
    // spawn corner kept open
    if ((r == 1 && c == 1) || (r == 1 && c == 2) || (r == 2 && c == 1)) return TILE_FREE;
    if ((r + c) % 3 == 0) return TILE_BRICK;
    return TILE_FREE;
  endfunction

  // row-major cell index
  assign wr_addr    = ADDR_WIDTH'(i_wr_row * MAP_NUM_COL + i_wr_col);
  assign rd_addr    = ADDR_WIDTH'(i_rd_row * MAP_NUM_COL + i_rd_col);
  assign wr_in_grid = (i_wr_row < ROW_WIDTH'(MAP_NUM_ROW)) && (i_wr_col < COL_WIDTH'(MAP_NUM_COL));
  assign rd_in_grid = (i_rd_row < ROW_WIDTH'(MAP_NUM_ROW)) && (i_rd_col < COL_WIDTH'(MAP_NUM_COL));

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < MAP_NUM_ROW; r++) begin
        for (int c = 0; c < MAP_NUM_COL; c++) begin
          mem[r * MAP_NUM_COL + c] <= init_tile(r, c);
        end
      end
    end else if (i_we && wr_in_grid) begin
      if (i_wr_op == OP_PLACE) begin
        mem[wr_addr] <= TILE_BOMB;
      // walls survive a blast
      end else if (mem[wr_addr] != TILE_WALL) begin
        mem[wr_addr] <= TILE_FREE;
      end
    end
  end

  // renderer port, one cycle latency; off-grid reads as wall
  always_ff @(posedge pixclk) begin
    o_rd_tile <= rd_in_grid ? mem[rd_addr] : TILE_WALL;
  end

endmodule

//--- logic/bomb_top.sv
module bomb_top (
  input  logic                              pixclk,
  input  logic                              i_rst_n,
  input  logic                              i_tick,
  input  logic                              i_place_bomb,
  input  logic [bomb_pkg::ROW_WIDTH-1:0]    i_player_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0]    i_player_col,
  input  logic [bomb_pkg::ROW_WIDTH-1:0]    i_rd_row,
  input  logic [bomb_pkg::COL_WIDTH-1:0]    i_rd_col,
  output bomb_pkg::tile_t                   o_rd_tile,
  output logic [bomb_pkg::FUSE_WIDTH-1:0]   o_countdown,
  output logic [bomb_pkg::ACTIVE_WIDTH-1:0] o_bombs_active,
  output logic                              o_blast,
  output logic                              o_game_over
);
  import bomb_pkg::*;

  // dispatcher to slots
  logic [NUM_BOMBS-1:0]  arm;
  logic [ROW_WIDTH-1:0]  arm_row;
  logic [COL_WIDTH-1:0]  arm_col;
  // slots back to dispatcher
  logic [NUM_BOMBS-1:0]  slot_busy;
  logic [ROW_WIDTH-1:0]  slot_row [NUM_BOMBS];
  logic [COL_WIDTH-1:0]  slot_col [NUM_BOMBS];
  // slots to collector
  logic [NUM_BOMBS-1:0]  req;
  wr_op_t                op [NUM_BOMBS];
  logic [ROW_WIDTH-1:0]  req_row [NUM_BOMBS];
  logic [COL_WIDTH-1:0]  req_col [NUM_BOMBS];
  logic [FUSE_WIDTH-1:0] fuse_left [NUM_BOMBS];
  logic [NUM_BOMBS-1:0]  blasting;
  logic [NUM_BOMBS-1:0]  grant;
  // collector to map
  logic                  we;
  wr_op_t                wr_op;
  logic [ROW_WIDTH-1:0]  wr_row;
  logic [COL_WIDTH-1:0]  wr_col;

  bomb_dispatch u_dispatch (
    .pixclk       (pixclk),
    .i_rst_n      (i_rst_n),
    .i_place_bomb (i_place_bomb),
    .i_player_row (i_player_row),
    .i_player_col (i_player_col),
    .i_slot_busy  (slot_busy),
    .i_slot_row   (slot_row),
    .i_slot_col   (slot_col),
    .o_arm        (arm),
    .o_arm_row    (arm_row),
    .o_arm_col    (arm_col)
  );

  // identical bomb slots
  for (genvar gi = 0; gi < NUM_BOMBS; gi++) begin : g_slot
    bomb_slot u_slot (
      .pixclk      (pixclk),
      .i_rst_n     (i_rst_n),
      .i_tick      (i_tick),
      .i_arm       (arm[gi]),
      .i_arm_row   (arm_row),
      .i_arm_col   (arm_col),
      .i_grant     (grant[gi]),
      .o_busy      (slot_busy[gi]),
      .o_row       (slot_row[gi]),
      .o_col       (slot_col[gi]),
      .o_req       (req[gi]),
      .o_op        (op[gi]),
      .o_req_row   (req_row[gi]),
      .o_req_col   (req_col[gi]),
      .o_fuse_left (fuse_left[gi]),
      .o_blasting  (blasting[gi])
    );
  end

  bomb_collector u_collector (
    .pixclk         (pixclk),
    .i_rst_n        (i_rst_n),
    .i_req          (req),
    .i_op           (op),
    .i_req_row      (req_row),
    .i_req_col      (req_col),
    .i_fuse_left    (fuse_left),
    .i_fuse_valid   (slot_busy),
    .i_blasting     (blasting),
    .i_player_row   (i_player_row),
    .i_player_col   (i_player_col),
    .o_grant        (grant),
    .o_we           (we),
    .o_wr_op        (wr_op),
    .o_wr_row       (wr_row),
    .o_wr_col       (wr_col),
    .o_countdown    (o_countdown),
    .o_bombs_active (o_bombs_active),
    .o_blast        (o_blast),
    .o_game_over    (o_game_over)
  );

  tile_map u_map (
    .pixclk    (pixclk),
    .i_rst_n   (i_rst_n),
    .i_we      (we),
    .i_wr_op   (wr_op),
    .i_wr_row  (wr_row),
    .i_wr_col  (wr_col),
    .i_rd_row  (i_rd_row),
    .i_rd_col  (i_rd_col),
    .o_rd_tile (o_rd_tile)
  );

endmodule

//--- testbench/bomb_checker.sv
module bomb_checker (
  input logic                           pixclk,
  input logic                           i_rst_n,
  input logic [bomb_pkg::NUM_BOMBS-1:0] i_req,
  input logic [bomb_pkg::NUM_BOMBS-1:0] o_grant,
  input logic                           o_we,
  input logic                           o_game_over
);
  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int assert_fails = 0;

  // at most one slot owns the map port
  a_grant_onehot0: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    $onehot0(o_grant))
  else begin
    assert_fails++;
    $error("grant not onehot0: %b", o_grant);
  end

  // a map write always belongs to a requesting, granted slot
  a_we_has_req: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    o_we |-> |(o_grant & i_req))
  else begin
    assert_fails++;
    $error("write enable without a granted request");
  end

  // no grant to an idle requester
  a_grant_to_req: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    (o_grant & ~i_req) == '0)
  else begin
    assert_fails++;
    $error("grant %b to a slot not requesting (%b)", o_grant, i_req);
  end

  // sticky until reset
  a_game_over_sticky: assert property (@(posedge pixclk)
    (i_rst_n && o_game_over) |=> o_game_over)
  else begin
    assert_fails++;
    $error("game over fell without reset");
  end

endmodule

//--- testbench/tb_bomb_top.sv
module tb_bomb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import bomb_pkg::*;

  logic                    pixclk;
  logic                    i_rst_n;
  logic                    i_tick;
  logic                    i_place_bomb;
  logic [ROW_WIDTH-1:0]    i_player_row;
  logic [COL_WIDTH-1:0]    i_player_col;
  logic [ROW_WIDTH-1:0]    i_rd_row;
  logic [COL_WIDTH-1:0]    i_rd_col;
  tile_t                   o_rd_tile;
  logic [FUSE_WIDTH-1:0]   o_countdown;
  logic [ACTIVE_WIDTH-1:0] o_bombs_active;
  logic                    o_blast;
  logic                    o_game_over;

  // expected map contents
  tile_t ref_map [MAP_NUM_ROW][MAP_NUM_COL];
  int    val_errs;
  int    tmo_errs;
  // read pipeline for the comparing process
  logic  rd_en;
  logic  chk_valid;
  int    chk_row;
  int    chk_col;

  bomb_top UUT (
    .pixclk         (pixclk),
    .i_rst_n        (i_rst_n),
    .i_tick         (i_tick),
    .i_place_bomb   (i_place_bomb),
    .i_player_row   (i_player_row),
    .i_player_col   (i_player_col),
    .i_rd_row       (i_rd_row),
    .i_rd_col       (i_rd_col),
    .o_rd_tile      (o_rd_tile),
    .o_countdown    (o_countdown),
    .o_bombs_active (o_bombs_active),
    .o_blast        (o_blast),
    .o_game_over    (o_game_over)
  );

  bind bomb_collector bomb_checker u_checker (
    .pixclk      (pixclk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .o_grant     (o_grant),
    .o_we        (o_we),
    .o_game_over (o_game_over)
  );

  initial begin
    pixclk = 1'b0;
    forever #4 pixclk = ~pixclk;
  end

  // start layout: border and even/even pillars, bricks on thirds, spawn corner open
  function automatic tile_t start_tile(input int r, input int c);
    bit edge_cell;
    bit pillar;
    bit spawn;
    edge_cell = (r == 0) || (c == 0) || (r == MAP_NUM_ROW - 1) || (c == MAP_NUM_COL - 1);
    pillar    = (r % 2 == 0) && (c % 2 == 0);
    // (1,1), (1,2) and (2,1)
    spawn     = (r >= 1) && (c >= 1) && (r + c <= 3);
    if (edge_cell || pillar) return TILE_WALL;
    if (!spawn && (r + c) % 3 == 0) return TILE_BRICK;
    return TILE_FREE;
  endfunction

  function automatic void init_ref_map();
    for (int r = 0; r < MAP_NUM_ROW; r++) begin
      for (int c = 0; c < MAP_NUM_COL; c++) begin
        ref_map[r][c] = start_tile(r, c);
      end
    end
  endfunction

  // off-grid writes vanish, walls shrug off clears
  function automatic void apply_write(input wr_op_t op, input int r, input int c);
    if (r < 0 || c < 0 || r >= MAP_NUM_ROW || c >= MAP_NUM_COL) return;
    if (op == OP_PLACE) begin
      ref_map[r][c] = TILE_BOMB;
    end else if (ref_map[r][c] != TILE_WALL) begin
      ref_map[r][c] = TILE_FREE;
    end
  endfunction

  function automatic void apply_blast(input int r, input int c);
    apply_write(OP_CLEAR, r, c);
    apply_write(OP_CLEAR, r - 1, c);
    apply_write(OP_CLEAR, r + 1, c);
    apply_write(OP_CLEAR, r, c - 1);
    apply_write(OP_CLEAR, r, c + 1);
  endfunction

  // random interior free cell
  function automatic void pick_free(output int r, output int c);
    r = 1;
    c = 1;
    for (int n = 0; n < 1000; n++) begin
      r = $urandom_range(1, MAP_NUM_ROW - 2);
      c = $urandom_range(1, MAP_NUM_COL - 2);
      if (ref_map[r][c] == TILE_FREE) return;
    end
  endfunction

  task automatic expect_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic move_player(input int r, input int c);
    @(posedge pixclk);
    i_player_row <= ROW_WIDTH'(r);
    i_player_col <= COL_WIDTH'(c);
  endtask

  // player steps on the cell and presses place for one cycle
  task automatic drop_bomb(input int r, input int c);
    @(posedge pixclk);
    i_player_row <= ROW_WIDTH'(r);
    i_player_col <= COL_WIDTH'(c);
    i_place_bomb <= 1'b1;
    @(posedge pixclk);
    i_place_bomb <= 1'b0;
  endtask

  // returns at a falling edge with outputs settled
  task automatic pulse_tick(input int gap);
    repeat (gap) @(posedge pixclk);
    @(posedge pixclk);
    i_tick <= 1'b1;
    @(posedge pixclk);
    i_tick <= 1'b0;
    @(negedge pixclk);
  endtask

  task automatic wait_active(input int n);
    for (int k = 0; k < 200; k++) begin
      @(negedge pixclk);
      if (o_bombs_active == n) return;
    end
    $display("timeout: bomb count never reached %0d", n);
    tmo_errs++;
  endtask

  task automatic wait_blast();
    for (int k = 0; k < 200; k++) begin
      @(negedge pixclk);
      if (o_blast) return;
    end
    $display("timeout: blast never started");
    tmo_errs++;
  endtask

  // place write wins arbitration within NUM_BOMBS cycles of busy
  task automatic settle_place(input int r, input int c);
    repeat (NUM_BOMBS + 1) @(posedge pixclk);
    @(negedge pixclk);
    apply_write(OP_PLACE, r, c);
  endtask

  task automatic drain_bombs();
    for (int k = 0; k < 50; k++) begin
      if (o_bombs_active == 0) return;
      pulse_tick($urandom_range(0, 6));
    end
    $display("timeout: bombs still active after 50 ticks");
    tmo_errs++;
  endtask

  // one read per cycle, checked by the comparing process
  task automatic sweep_map();
    for (int r = 0; r < MAP_NUM_ROW; r++) begin
      for (int c = 0; c < MAP_NUM_COL; c++) begin
        @(posedge pixclk);
        rd_en    <= 1'b1;
        i_rd_row <= ROW_WIDTH'(r);
        i_rd_col <= COL_WIDTH'(c);
      end
    end
    @(posedge pixclk);
    rd_en <= 1'b0;
    repeat (2) @(posedge pixclk);
    @(negedge pixclk);
  endtask

  // address driven last cycle, tile registered this edge
  always @(posedge pixclk) begin
    chk_valid <= rd_en;
    chk_row   <= int'(i_rd_row);
    chk_col   <= int'(i_rd_col);
  end

  always @(negedge pixclk) begin
    if (chk_valid && o_rd_tile !== ref_map[chk_row][chk_col]) begin
      $display("FAILED o_rd_tile (%0d,%0d): got %h expected %h",
               chk_row, chk_col, o_rd_tile, ref_map[chk_row][chk_col]);
      val_errs++;
    end
  end

  initial begin
    int ra, ca;
    int rb, cb;
    int rc, cc;
    int rd, cd;
    int fails;
    void'($urandom(76743));
    val_errs     = 0;
    tmo_errs     = 0;
    i_rst_n      = 1'b0;
    i_tick       = 1'b0;
    i_place_bomb = 1'b0;
    i_player_row = '0;
    i_player_col = '0;
    i_rd_row     = '0;
    i_rd_col     = '0;
    rd_en        = 1'b0;
    init_ref_map();
    repeat (16) @(posedge pixclk);
    i_rst_n <= 1'b1;
    @(negedge pixclk);

    // reset contents and idle outputs
    sweep_map();
    expect_val("o_bombs_active", o_bombs_active, 0);
    expect_val("o_blast", o_blast, 0);
    expect_val("o_game_over", o_game_over, 0);

    // single bomb, player walks off to the corner
    pick_free(ra, ca);
    drop_bomb(ra, ca);
    move_player(0, 0);
    wait_active(1);
    settle_place(ra, ca);
    sweep_map();
    expect_val("o_bombs_active", o_bombs_active, 1);
    expect_val("o_countdown", o_countdown, FUSE_TICKS);
    for (int i = 1; i <= FUSE_TICKS; i++) begin
      pulse_tick($urandom_range(0, 6));
      expect_val("o_countdown", o_countdown, FUSE_TICKS - i);
    end
    wait_blast();
    apply_blast(ra, ca);
    sweep_map();
    for (int i = 1; i <= BLAST_TICKS; i++) begin
      pulse_tick($urandom_range(0, 6));
      expect_val("o_blast", o_blast, i < BLAST_TICKS);
    end
    expect_val("o_bombs_active", o_bombs_active, 0);
    expect_val("o_game_over", o_game_over, 0);

    // first bomb, then a duplicate on its cell
    pick_free(ra, ca);
    drop_bomb(ra, ca);
    wait_active(1);
    settle_place(ra, ca);
    drop_bomb(ra, ca);
    repeat (4) @(posedge pixclk);
    @(negedge pixclk);
    expect_val("o_bombs_active", o_bombs_active, 1);
    pulse_tick($urandom_range(0, 6));
    // second and third bombs, one tick apart
    pick_free(rb, cb);
    drop_bomb(rb, cb);
    wait_active(2);
    settle_place(rb, cb);
    pulse_tick($urandom_range(0, 6));
    pick_free(rc, cc);
    drop_bomb(rc, cc);
    wait_active(3);
    settle_place(rc, cc);
    expect_val("o_countdown", o_countdown, FUSE_TICKS - 2);
    // all slots taken
    pick_free(rd, cd);
    drop_bomb(rd, cd);
    repeat (4) @(posedge pixclk);
    @(negedge pixclk);
    expect_val("o_bombs_active", o_bombs_active, 3);
    move_player(0, 0);
    sweep_map();
    // oldest bomb sets the countdown until it blows
    for (int i = 1; i < FUSE_TICKS - 2; i++) begin
      pulse_tick($urandom_range(0, 6));
      expect_val("o_countdown", o_countdown, FUSE_TICKS - 2 - i);
    end
    pulse_tick($urandom_range(0, 6));
    expect_val("o_countdown", o_countdown, 1);
    // back-to-back tick overlaps the first two bursts
    pulse_tick(0);
    expect_val("o_countdown", o_countdown, 1);
    drain_bombs();
    apply_blast(ra, ca);
    apply_blast(rb, cb);
    apply_blast(rc, cc);
    sweep_map();
    expect_val("o_game_over", o_game_over, 0);

    // player stays on the bomb
    pick_free(ra, ca);
    drop_bomb(ra, ca);
    wait_active(1);
    settle_place(ra, ca);
    repeat (FUSE_TICKS) pulse_tick($urandom_range(0, 6));
    wait_blast();
    expect_val("o_game_over", o_game_over, 1);
    drain_bombs();
    apply_blast(ra, ca);
    sweep_map();
    expect_val("o_game_over", o_game_over, 1);

    fails = UUT.u_collector.u_checker.assert_fails;
    $display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             val_errs, tmo_errs, fails);
    if (val_errs == 0 && tmo_errs == 0 && fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/bomb_pkg.sv
logic/bomb_dispatch.sv
logic/bomb_slot.sv
logic/bomb_collector.sv
logic/tile_map.sv
logic/bomb_top.sv
testbench/bomb_checker.sv
testbench/tb_bomb_top.sv

//--- Bender.yml
package:
  name: bomb_subsystem

dependencies: {}

sources:
  # design, package first
  - files:
      - logic/bomb_pkg.sv
      - logic/bomb_dispatch.sv
      - logic/bomb_slot.sv
      - logic/bomb_collector.sv
      - logic/tile_map.sv
      - logic/bomb_top.sv

  # simulation only
  - target: test
    files:
      - testbench/bomb_checker.sv
      - testbench/tb_bomb_top.sv
